/* rtl/cpu_settings.svh */
`ifndef CPU_SETTINGS_SVH
`define CPU_SETTINGS_SVH

`define CPU_WORD_W   32
`define CPU_REG_N    32
`define CPU_BP_DEPTH 16
`define CPU_RESET_PC 32'h0000_0000

`endif

/* rtl/cpu_types_pkg.sv */
`include "cpu_settings.svh"

package cpu_types_pkg;

    typedef logic [`CPU_WORD_W-1:0] word_t;

    typedef enum logic [5:0] {
        RTYPE = 6'h00,
        JAL   = 6'h03,
        BEQ   = 6'h04,
        BNE   = 6'h05,
        ADDIU = 6'h09,
        LW    = 6'h23,
        SW    = 6'h2b,
        HALT  = 6'h3f
    } opcode_t;

    typedef enum logic [5:0] {
        JR   = 6'h08,
        ADDU = 6'h21,
        SUBU = 6'h23
    } funct_t;

    // Control-flow kind, resolved in MEM.
    typedef enum logic [2:0] {
        PCSRC_NEXT,
        PCSRC_BEQ,
        PCSRC_BNE,
        PCSRC_JAL,
        PCSRC_REG
    } pcsrc_t;

    typedef enum logic [1:0] {
        BPRED_NS = 2'b00,
        BPRED_NH = 2'b01,
        BPRED_TH = 2'b10,
        BPRED_TS = 2'b11
    } bpred_t;

endpackage

/* rtl/branch_predictor.sv */
`include "cpu_settings.svh"

module branch_predictor (
    input  logic                   CLK,
    input  logic                   rst_n,
    input  cpu_types_pkg::word_t   lookup_pc,
    output cpu_types_pkg::bpred_t  lookup_stat,
    input  logic                   update_en,
    input  cpu_types_pkg::word_t   update_pc,
    input  logic                   update_taken
);
    import cpu_types_pkg::*;

    localparam int IDX_W = $clog2(`CPU_BP_DEPTH);

    bpred_t              cnt_tbl [`CPU_BP_DEPTH];
    logic [IDX_W-1:0]    upd_idx;
    bpred_t              upd_cur;

    assign lookup_stat = cnt_tbl[lookup_pc[IDX_W+1:2]]; // Word address bits.
    assign upd_idx     = update_pc[IDX_W+1:2];
    assign upd_cur     = cnt_tbl[upd_idx];

    always_ff @(posedge CLK) begin
        if (!rst_n) begin
            for (int i = 0; i < `CPU_BP_DEPTH; i++) begin
                cnt_tbl[i] <= BPRED_NH;
            end
        end else if (update_en) begin
            if (update_taken && upd_cur != BPRED_TS) begin
                cnt_tbl[upd_idx] <= bpred_t'(upd_cur + 2'd1);
            end else if (!update_taken && upd_cur != BPRED_NS) begin
                cnt_tbl[upd_idx] <= bpred_t'(upd_cur - 2'd1);
            end
        end
    end

endmodule

/* rtl/hazard_unit.sv */
`include "cpu_settings.svh"

module hazard_unit (
    input  logic                              ex_memren,
    input  logic                              ex_regwen,
    input  logic [$clog2(`CPU_REG_N)-1:0]     ex_rd,
    input  logic [$clog2(`CPU_REG_N)-1:0]     id_rs,
    input  logic [$clog2(`CPU_REG_N)-1:0]     id_rt,
    input  cpu_types_pkg::pcsrc_t             mem_pcsrc,
    input  logic                              mem_zero,
    input  cpu_types_pkg::bpred_t             mem_bp_stat,
    input  logic                              wb_halt,
    input  logic                              imem_wait,
    input  logic                              dmem_wait,
    output logic                              pcen,
    output logic                              if_id_en,
    output logic                              id_ex_en,
    output logic                              ex_mem_en,
    output logic                              mem_wb_en,
    output logic                              if_id_flush,
    output logic                              id_ex_flush,
    output logic                              ex_mem_flush,
    output logic                              mem_wb_flush,
    output logic                              phit
);
    import cpu_types_pkg::*;

    logic predict_taken, branch_taken;

    always_comb begin
        {pcen, if_id_en, id_ex_en, ex_mem_en, mem_wb_en} = '1;
        {if_id_flush, id_ex_flush, ex_mem_flush, mem_wb_flush} = '0;

        predict_taken = mem_bp_stat inside {BPRED_TH, BPRED_TS};
        branch_taken  = (mem_pcsrc == PCSRC_BEQ) ? mem_zero : ~mem_zero;
        case (mem_pcsrc)
            PCSRC_BEQ, PCSRC_BNE: phit = (branch_taken == predict_taken);
            PCSRC_JAL, PCSRC_REG: phit = 1'b0; // Never predicted.
            default:              phit = 1'b1;
        endcase

        // Load in EX feeds the instruction in ID.
        if (ex_memren && ex_regwen && (|ex_rd) && (ex_rd == id_rs || ex_rd == id_rt)) begin
            id_ex_flush = 1'b1;
            if_id_en    = 1'b0;
            pcen        = 1'b0;
        end

        if (!phit) begin
            pcen         = 1'b1;
            if_id_en     = 1'b1;
            if_id_flush  = 1'b1;
            id_ex_flush  = 1'b1;
            ex_mem_flush = 1'b1;
        end

        // Halt and memory wait freeze everything, wait having the last word.
        if (wb_halt || imem_wait || dmem_wait) begin
            {pcen, if_id_en, id_ex_en, ex_mem_en, mem_wb_en} = '0;
            {if_id_flush, id_ex_flush, ex_mem_flush, mem_wb_flush} = '0;
        end
    end

endmodule

/* rtl/mem_arbiter.sv */
`include "cpu_settings.svh"

module mem_arbiter (
    input  logic                       CLK,
    input  logic                       rst_n,
    input  logic                       ireq,
    input  cpu_types_pkg::word_t       iaddr,
    output cpu_types_pkg::word_t       irdata,
    output logic                       idone,
    input  logic                       dreq,
    input  logic                       dwen,
    input  cpu_types_pkg::word_t       daddr,
    input  cpu_types_pkg::word_t       dwdata,
    output cpu_types_pkg::word_t       drdata,
    output logic                       ddone,
    output logic                       awvalid,
    input  logic                       awready,
    output cpu_types_pkg::word_t       awaddr,
    output logic                       wvalid,
    input  logic                       wready,
    output cpu_types_pkg::word_t       wdata,
    output logic [`CPU_WORD_W/8-1:0]   wstrb,
    input  logic                       bvalid,
    output logic                       bready,
    output logic                       arvalid,
    input  logic                       arready,
    output cpu_types_pkg::word_t       araddr,
    input  logic                       rvalid,
    output logic                       rready,
    input  cpu_types_pkg::word_t       rdata
);
    typedef enum logic [2:0] {S_IDLE, S_AR, S_R, S_AW, S_B, S_DONE} state_t;

    state_t                  state;
    logic                    owner_d;      // Grant went to the data client.
    logic                    aw_ok, w_ok;
    logic [`CPU_WORD_W-1:0]  addr_q, wdata_q, rdata_q;

    always_ff @(posedge CLK) begin
        if (!rst_n) begin
            state   <= S_IDLE;
            owner_d <= 1'b0;
            aw_ok   <= 1'b0;
            w_ok    <= 1'b0;
        end else begin
            case (state)
                S_IDLE: begin
                    aw_ok <= 1'b0;
                    w_ok  <= 1'b0;
                    if (dreq) begin                        // Data wins.
                        owner_d <= 1'b1;
                        addr_q  <= daddr;
                        wdata_q <= dwdata;
                        state   <= dwen ? S_AW : S_AR;
                    end else if (ireq) begin
                        owner_d <= 1'b0;
                        addr_q  <= iaddr;
                        state   <= S_AR;
                    end
                end
                S_AR: if (arready) state <= S_R;
                S_R: begin
                    if (rvalid) begin
                        rdata_q <= rdata;
                        state   <= S_DONE;
                    end
                end
                S_AW: begin
                    if (awready) aw_ok <= 1'b1;
                    if (wready) w_ok <= 1'b1;
                    if ((aw_ok || awready) && (w_ok || wready)) state <= S_B;
                end
                S_B: if (bvalid) state <= S_DONE;
                default: state <= S_IDLE;
            endcase
        end
    end

    assign arvalid = (state == S_AR);
    assign araddr  = addr_q;
    assign rready  = (state == S_R);
    assign awvalid = (state == S_AW) && !aw_ok;
    assign wvalid  = (state == S_AW) && !w_ok;
    assign awaddr  = addr_q;
    assign wdata   = wdata_q;
    assign wstrb   = '1;                          // Word accesses only.
    assign bready  = (state == S_B);

    assign idone  = (state == S_DONE) && !owner_d;
    assign ddone  = (state == S_DONE) && owner_d;
    assign irdata = rdata_q;
    assign drdata = rdata_q;

endmodule

/* rtl/pipeline_datapath.sv */
`include "cpu_settings.svh"

module pipeline_datapath (
    input  logic CLK, rst_n,
    input  logic pcen, if_id_en, id_ex_en, ex_mem_en, mem_wb_en,
    input  logic if_id_flush, id_ex_flush, ex_mem_flush, mem_wb_flush, phit,
    output logic ex_memren, ex_regwen,
    output logic [$clog2(`CPU_REG_N)-1:0] ex_rd, id_rs, id_rt,
    output cpu_types_pkg::pcsrc_t mem_pcsrc,
    output logic mem_zero,
    output cpu_types_pkg::bpred_t mem_bp_stat,
    output logic wb_halt,
    output cpu_types_pkg::word_t bp_lookup_pc,
    input  cpu_types_pkg::bpred_t bp_lookup_stat,
    output logic bp_update_en, bp_update_taken,
    output cpu_types_pkg::word_t bp_update_pc,
    output logic ireq,
    output cpu_types_pkg::word_t iaddr,
    input  cpu_types_pkg::word_t irdata,
    input  logic idone,
    output logic dreq, dwen,
    output cpu_types_pkg::word_t daddr, dwdata,
    input  cpu_types_pkg::word_t drdata,
    input  logic ddone
);
    import cpu_types_pkg::*;

    localparam int RW = $clog2(`CPU_REG_N);

    typedef struct packed {word_t pc4, instr; bpred_t bp;} if_id_t;
    typedef struct packed {
        pcsrc_t pcsrc; logic regwen, memren, memwen, halt, sub, use_imm;
        logic [RW-1:0] rs, rt, rd; word_t pc4, rs_val, rt_val, imm; bpred_t bp;
    } id_ex_t;
    typedef struct packed {
        pcsrc_t pcsrc; logic regwen, memren, memwen, halt, zero;
        logic [RW-1:0] rd; word_t res, wdata, target, pc4; bpred_t bp;
    } ex_mem_t;
    typedef struct packed {logic regwen, halt; logic [RW-1:0] rd; word_t res;} mem_wb_t;

    word_t   pc, pc4_f, instr_f, ibuf, f_imm, rs_rd, rt_rd, a_fwd, b_fwd, alu, load_val;
    word_t   mem_next, dbuf, regs [`CPU_REG_N];
    logic    ibuf_v, f_jump, dflag, mem_taken;
    opcode_t f_op, d_op;
    if_id_t  fd;
    id_ex_t  de, dec;
    ex_mem_t em, ex_next;
    mem_wb_t mw;

    // Fetch and predecode.
    assign instr_f      = ibuf_v ? ibuf : irdata;
    assign ireq         = !ibuf_v && !mw.halt;
    assign iaddr        = pc;
    assign bp_lookup_pc = pc;
    assign pc4_f        = pc + 4;
    assign f_op         = opcode_t'(instr_f[31:26]);
    assign f_imm        = {{(`CPU_WORD_W-16){instr_f[15]}}, instr_f[15:0]};
    assign f_jump       = (f_op == BEQ || f_op == BNE) && bp_lookup_stat[1];

    always_ff @(posedge CLK) begin
        if (!rst_n) pc <= `CPU_RESET_PC;
        else if (pcen) pc <= !phit ? mem_next : (f_jump ? pc4_f + (f_imm << 2) : pc4_f);
    end

    always_ff @(posedge CLK) begin // Holds a word that arrived during a stall.
        if (!rst_n || pcen) begin
            ibuf_v <= 1'b0;
        end else if (idone) begin
            ibuf_v <= 1'b1;
            ibuf   <= irdata;
        end
    end

    always_ff @(posedge CLK) begin
        if (!rst_n || if_id_flush) fd <= '0;
        else if (if_id_en) fd <= '{pc4: pc4_f, instr: instr_f, bp: bp_lookup_stat};
    end

    // Decode with write-first register read.
    assign d_op  = opcode_t'(fd.instr[31:26]);
    assign id_rs = fd.instr[25:21];
    assign id_rt = fd.instr[20:16];
    assign rs_rd = (id_rs == '0) ? '0 : (mw.regwen && mw.rd == id_rs) ? mw.res : regs[id_rs];
    assign rt_rd = (id_rt == '0) ? '0 : (mw.regwen && mw.rd == id_rt) ? mw.res : regs[id_rt];

    always_comb begin
        dec        = '0;
        dec.rs     = id_rs;
        dec.rt     = id_rt;
        dec.rs_val = rs_rd;
        dec.rt_val = rt_rd;
        dec.pc4    = fd.pc4;
        dec.bp     = fd.bp;
        dec.imm    = {{(`CPU_WORD_W-16){fd.instr[15]}}, fd.instr[15:0]};
        case (d_op)
            RTYPE: begin
                dec.rd     = fd.instr[15:11];
                dec.sub    = (fd.instr[5:0] == SUBU);
                dec.regwen = (fd.instr[5:0] == ADDU) || (fd.instr[5:0] == SUBU);
                if (fd.instr[5:0] == JR) dec.pcsrc = PCSRC_REG;
            end
            ADDIU: {dec.use_imm, dec.regwen, dec.rd} = {2'b11, id_rt};
            LW:    {dec.use_imm, dec.regwen, dec.memren, dec.rd} = {3'b111, id_rt};
            SW:    {dec.use_imm, dec.memwen} = 2'b11;
            BEQ:   {dec.sub, dec.pcsrc} = {1'b1, PCSRC_BEQ};
            BNE:   {dec.sub, dec.pcsrc} = {1'b1, PCSRC_BNE};
            JAL: begin
                {dec.regwen, dec.rd, dec.pcsrc} = {1'b1, RW'(31), PCSRC_JAL};
                dec.imm = {fd.pc4[31:28], fd.instr[25:0], 2'b00}; // Jump target.
            end
            HALT:  dec.halt = 1'b1;
            default: ;
        endcase
    end

    always_ff @(posedge CLK) begin
        if (!rst_n || id_ex_flush) de <= '0;
        else if (id_ex_en) de <= dec;
    end

    // Execute. MEM result first, then WB.
    function automatic word_t fwd(logic [RW-1:0] r, word_t v);
        if (em.regwen && r != '0 && em.rd == r) return em.res;
        if (mw.regwen && r != '0 && mw.rd == r) return mw.res;
        return v;
    endfunction

    assign a_fwd     = fwd(de.rs, de.rs_val);
    assign b_fwd     = fwd(de.rt, de.rt_val);
    assign alu       = de.sub ? a_fwd - (de.use_imm ? de.imm : b_fwd)
                              : a_fwd + (de.use_imm ? de.imm : b_fwd);
    assign ex_memren = de.memren;
    assign ex_regwen = de.regwen;
    assign ex_rd     = de.rd;

    always_comb begin
        ex_next = '{pcsrc: de.pcsrc, regwen: de.regwen, memren: de.memren,
                    memwen: de.memwen, halt: de.halt, zero: (alu == '0), rd: de.rd,
                    res: (de.pcsrc == PCSRC_JAL) ? de.pc4 : alu, wdata: b_fwd,
                    target: de.pc4 + (de.imm << 2), pc4: de.pc4, bp: de.bp};
        if (de.pcsrc == PCSRC_REG) ex_next.target = a_fwd;
        else if (de.pcsrc == PCSRC_JAL) ex_next.target = de.imm;
    end

    always_ff @(posedge CLK) begin
        if (!rst_n || ex_mem_flush) em <= '0;
        else if (ex_mem_en) em <= ex_next;
    end

    // Memory access and branch resolution.
    assign dreq     = (em.memren || em.memwen) && !dflag;
    assign dwen     = em.memwen;
    assign daddr    = em.res;
    assign dwdata   = em.wdata;
    assign load_val = dflag ? dbuf : drdata;

    always_ff @(posedge CLK) begin // Access already done while MEM is held.
        if (!rst_n || mem_wb_en) begin
            dflag <= 1'b0;
        end else if (ddone) begin
            dflag <= 1'b1;
            dbuf  <= drdata;
        end
    end

    assign mem_pcsrc   = em.pcsrc;
    assign mem_zero    = em.zero;
    assign mem_bp_stat = em.bp;
    assign mem_taken   = (em.pcsrc == PCSRC_BEQ) ? em.zero :
                         (em.pcsrc == PCSRC_BNE) ? !em.zero :
                         (em.pcsrc == PCSRC_JAL || em.pcsrc == PCSRC_REG);
    assign mem_next        = mem_taken ? em.target : em.pc4;
    assign bp_update_en    = (em.pcsrc == PCSRC_BEQ || em.pcsrc == PCSRC_BNE) && mem_wb_en;
    assign bp_update_pc    = em.pc4 - 4;
    assign bp_update_taken = mem_taken;

    always_ff @(posedge CLK) begin
        if (!rst_n || mem_wb_flush) mw <= '0;
        else if (mem_wb_en) mw <= '{regwen: em.regwen, halt: em.halt, rd: em.rd,
                                    res: em.memren ? load_val : em.res};
    end

    // Write back.
    always_ff @(posedge CLK) begin
        if (mw.regwen && mw.rd != '0) regs[mw.rd] <= mw.res;
    end

    assign wb_halt = mw.halt;

endmodule

/* rtl/cpu_top.sv */
`include "cpu_settings.svh"

module cpu_top (
    input  logic                       CLK,
    input  logic                       rst_n,
    output logic                       awvalid,
    input  logic                       awready,
    output cpu_types_pkg::word_t       awaddr,
    output logic                       wvalid,
    input  logic                       wready,
    output cpu_types_pkg::word_t       wdata,
    output logic [`CPU_WORD_W/8-1:0]   wstrb,
    input  logic                       bvalid,
    output logic                       bready,
    output logic                       arvalid,
    input  logic                       arready,
    output cpu_types_pkg::word_t       araddr,
    input  logic                       rvalid,
    output logic                       rready,
    input  cpu_types_pkg::word_t       rdata,
    output logic                       halt
);
    import cpu_types_pkg::*;

    logic pcen, if_id_en, id_ex_en, ex_mem_en, mem_wb_en, phit;
    logic if_id_flush, id_ex_flush, ex_mem_flush, mem_wb_flush;
    logic ex_memren, ex_regwen, mem_zero, wb_halt, imem_wait, dmem_wait;
    logic [$clog2(`CPU_REG_N)-1:0] ex_rd, id_rs, id_rt;
    pcsrc_t mem_pcsrc;
    bpred_t mem_bp_stat, bp_lookup_stat;
    logic   bp_update_en, bp_update_taken, ireq, idone, dreq, dwen, ddone;
    word_t  bp_lookup_pc, bp_update_pc, iaddr, irdata, daddr, dwdata, drdata;

    assign imem_wait = ireq && !idone;
    assign dmem_wait = dreq && !ddone;
    assign halt      = wb_halt;

    pipeline_datapath pipeline_datapath_inst (.*);

    branch_predictor branch_predictor_inst (
        .CLK, .rst_n, .lookup_pc(bp_lookup_pc), .lookup_stat(bp_lookup_stat),
        .update_en(bp_update_en), .update_pc(bp_update_pc), .update_taken(bp_update_taken)
    );

    hazard_unit hazard_unit_inst (.*);

    mem_arbiter mem_arbiter_inst (.*);

endmodule

/* bench/cpu_props.sv */
module cpu_props (
    input logic                  CLK,
    input logic                  rst_n,
    input logic                  arvalid,
    input logic                  arready,
    input logic                  rvalid,
    input logic                  rready,
    input logic                  awvalid,
    input logic                  awready,
    input logic                  wvalid,
    input logic                  wready,
    input logic                  bvalid,
    input logic                  bready,
    input cpu_types_pkg::word_t  araddr,
    input cpu_types_pkg::word_t  awaddr,
    input cpu_types_pkg::word_t  wdata,
    input logic                  ireq,
    input logic                  idone,
    input logic                  dreq,
    input logic                  ddone,
    input logic                  if_id_flush,
    input logic                  id_ex_flush,
    input logic                  ex_mem_flush,
    input logic                  mem_wb_flush
);
    timeunit 1ns;
    timeprecision 100ps;

    logic busy; // An accepted AR or AW whose R or B has not completed.

    always_ff @(posedge CLK) begin
        if (!rst_n) begin
            busy <= 1'b0;
        end else if ((rvalid && rready) || (bvalid && bready)) begin
            busy <= 1'b0;
        end else if ((arvalid && arready) || (awvalid && awready)) begin
            busy <= 1'b1;
        end
    end

    ar_hold: assert property (@(posedge CLK) disable iff (!rst_n)
        arvalid && !arready |=> arvalid && $stable(araddr))
        else $error("arvalid dropped or araddr moved before arready");

    aw_hold: assert property (@(posedge CLK) disable iff (!rst_n)
        awvalid && !awready |=> awvalid && $stable(awaddr))
        else $error("awvalid dropped or awaddr moved before awready");

    w_hold: assert property (@(posedge CLK) disable iff (!rst_n)
        wvalid && !wready |=> wvalid && $stable(wdata))
        else $error("wvalid dropped or wdata moved before wready");

    one_txn: assert property (@(posedge CLK) disable iff (!rst_n)
        busy |-> !arvalid && !awvalid)
        else $error("new AXI request issued while another is outstanding");

    no_flush_in_wait: assert property (@(posedge CLK) disable iff (!rst_n)
        ((ireq && !idone) || (dreq && !ddone))
        |-> !(if_id_flush || id_ex_flush || ex_mem_flush || mem_wb_flush))
        else $error("pipeline flush during a memory wait");

endmodule

bind cpu_top cpu_props cpu_props_inst (.*);

/* bench/cpu_tb.sv */
module cpu_tb;
    timeunit 1ns;
    timeprecision 100ps;
    import cpu_types_pkg::*;

    localparam int          MEM_WORDS  = 256;
    localparam int          CLK_PERIOD = 100;
    localparam int          WORST_LAT  = 10;    // Cycles for one access at the longest waits.
    localparam int          MAX_STEPS  = 10000;
    localparam logic [15:0] SEED       = 16'd94;

    logic  CLK = 1'b0;
    logic  rst_n = 1'b0;
    logic  arready = 1'b0;
    logic  rvalid = 1'b0;
    logic  awready = 1'b0;
    logic  wready = 1'b0;
    logic  bvalid = 1'b0;
    word_t rdata = '0;
    logic  arvalid, rready, awvalid, wvalid, bready, halt;
    word_t araddr, awaddr, wdata;
    logic [3:0] wstrb;

    word_t       image [MEM_WORDS];
    word_t       mem [MEM_WORDS];
    word_t       exp_addr [$];
    word_t       exp_data [$];
    int          exp_test [$];
    int          test_err [4];
    int          store_seen [4];
    int          ref_count, err_cnt, aw_seen, w_seen, n_pass, n_fail, waited;
    bit          ref_ready;
    logic [15:0] lfsr_q = SEED;
    logic        ar_arm, r_arm, aw_arm, w_arm, b_arm, r_pend, aw_got, w_got;
    int          ar_cnt, r_cnt, aw_cnt, w_cnt, b_cnt;
    word_t       r_addr, aw_addr_q, w_data_q;

    cpu_top cpu_top_inst (.*);

    always #(CLK_PERIOD / 2) CLK = ~CLK;

    function automatic word_t enc_r(funct_t fn, int rs, int rt, int rd);
        return {RTYPE, 5'(rs), 5'(rt), 5'(rd), 5'd0, fn};
    endfunction

    function automatic word_t enc_i(opcode_t op, int rs, int rt, int imm);
        return {op, 5'(rs), 5'(rt), 16'(imm)};
    endfunction

    function automatic logic [15:0] lfsr_step(logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    function automatic int test_of(word_t a);
        int k;
        k = (a < 32'h200) ? 0 : int'((a - 32'h200) >> 6);
        return (k > 3) ? 3 : k;
    endfunction

    task automatic load_program();
        foreach (image[i]) image[i] = 32'hF8A5_0000 | word_t'(i << 2); // Opcode 0x3e decodes as no-op.
        image[0]  = enc_i(ADDIU, 0, 1, 5);     // ALU chain, stores at 0x200.
        image[1]  = enc_i(ADDIU, 1, 2, 7);
        image[2]  = enc_r(ADDU, 2, 1, 3);
        image[3]  = enc_r(SUBU, 3, 2, 4);
        image[4]  = enc_i(SW, 0, 3, 'h200);
        image[5]  = enc_i(SW, 0, 4, 'h204);
        image[6]  = enc_i(ADDIU, 4, 5, -3);
        image[7]  = enc_i(SW, 0, 5, 'h208);
        image[8]  = enc_i(LW, 0, 6, 'h100);    // Load-use, stores at 0x240.
        image[9]  = enc_i(ADDIU, 6, 7, 'h11);
        image[10] = enc_i(SW, 0, 7, 'h240);
        image[11] = enc_i(LW, 0, 8, 'h104);
        image[12] = enc_r(ADDU, 8, 7, 9);
        image[13] = enc_i(SW, 0, 9, 'h244);
        image[14] = enc_i(ADDIU, 0, 10, 4);    // Counted loop, stores at 0x280.
        image[15] = enc_i(ADDIU, 0, 11, 0);
        image[16] = enc_i(ADDIU, 0, 12, 'h280);
        image[17] = enc_r(ADDU, 11, 10, 11);
        image[18] = enc_i(SW, 12, 11, 0);
        image[19] = enc_i(ADDIU, 12, 12, 4);
        image[20] = enc_i(ADDIU, 10, 10, -1);
        image[21] = enc_i(BEQ, 10, 0, 1);
        image[22] = enc_i(BNE, 10, 0, -6);
        image[23] = enc_i(SW, 0, 11, 'h290);
        image[24] = enc_i(ADDIU, 0, 13, 'h2c0); // Call and return, stores at 0x2c0.
        image[25] = {JAL, 26'd32};
        image[26] = enc_i(SW, 13, 31, 4);
        image[27] = enc_i(SW, 13, 14, 8);
        image[28] = {HALT, 26'd0};
        image[32] = enc_r(ADDU, 31, 13, 14);
        image[33] = enc_i(SW, 13, 14, 0);
        image[34] = enc_r(JR, 31, 0, 0);
        image[35] = enc_i(SW, 0, 0, 'h2fc);    // Only ever on the wrong path.
    endtask

    // ISA interpreter; fills the expected store trace and counts instructions to HALT.
    function automatic int run_reference();
        word_t m [MEM_WORDS];
        word_t r [32];
        word_t pc, npc, ins, imm, ea;
        int    steps, rs, rt, rd;
        m = image;
        foreach (r[i]) r[i] = '0;
        pc = '0;
        for (steps = 1; steps <= MAX_STEPS; steps++) begin
            ins = m[pc[9:2]];
            rs  = int'(ins[25:21]);
            rt  = int'(ins[20:16]);
            rd  = int'(ins[15:11]);
            imm = {{16{ins[15]}}, ins[15:0]};
            ea  = r[rs] + imm;
            npc = pc + 4;
            case (ins[31:26])
                RTYPE: begin
                    if (ins[5:0] == ADDU) r[rd] = r[rs] + r[rt];
                    else if (ins[5:0] == SUBU) r[rd] = r[rs] - r[rt];
                    else if (ins[5:0] == JR) npc = r[rs];
                end
                ADDIU: r[rt] = ea;
                LW:    r[rt] = m[ea[9:2]];
                SW: begin
                    m[ea[9:2]] = r[rt];
                    exp_addr.push_back(ea);
                    exp_data.push_back(r[rt]);
                    exp_test.push_back(test_of(ea));
                end
                BEQ: if (r[rs] == r[rt]) npc = pc + 4 + (imm << 2);
                BNE: if (r[rs] != r[rt]) npc = pc + 4 + (imm << 2);
                JAL: begin
                    r[31] = pc + 4;
                    npc   = {npc[31:28], ins[25:0], 2'b00};
                end
                HALT: return steps;
                default: ;
            endcase
            r[0] = '0;
            pc   = npc;
        end
        return MAX_STEPS;
    endfunction

    task automatic draw_wait(output int w);
        w = 0;
        for (int i = 0; i < 2; i++) begin
            lfsr_q = lfsr_step(lfsr_q);
            w = (w << 1) | int'(lfsr_q[0]);
        end
        if (w > 0) waited++;
    endtask

    // Counts a drawn wait down while a handshake is pending.
    task automatic pace(input logic pending, inout logic armed, inout int cnt, output logic fire);
        if (!pending) begin
            armed = 1'b0;
        end else if (!armed) begin
            draw_wait(cnt);
            armed = 1'b1;
        end else if (cnt != 0) begin
            cnt = cnt - 1;
        end
        fire = pending && armed && (cnt == 0);
    endtask

    task automatic check_word(input string sig, input word_t got, input word_t exp, input int t);
        if (got !== exp) begin
            $display("ERR %0t %s got %h expected %h", $time, sig, got, exp);
            err_cnt++;
            test_err[t]++;
        end
    endtask

    task automatic report_test(input int id, input string name, input bit ok);
        $display("test %0d  %-36s %s", id, name, ok ? "pass" : "FAIL");
        if (ok) n_pass++;
        else n_fail++;
    endtask

    // AXI4-Lite memory.
    always @(posedge CLK) begin
        logic fire;
        if (!rst_n) begin
            {arready, rvalid, awready, wready, bvalid} <= '0;
            {ar_arm, r_arm, aw_arm, w_arm, b_arm} = '0;
            {r_pend, aw_got, w_got} = '0;
        end else begin
            if (arvalid && arready) begin
                arready <= 1'b0;
                r_addr = araddr;
                r_pend = 1'b1;
            end
            if (rvalid && rready) begin
                rvalid <= 1'b0;
                r_pend = 1'b0;
            end
            if (awvalid && awready) begin
                awready <= 1'b0;
                aw_addr_q = awaddr;
                aw_got = 1'b1;
            end
            if (wvalid && wready) begin
                wready <= 1'b0;
                w_data_q = wdata;
                w_got = 1'b1;
            end
            if (bvalid && bready) begin
                bvalid <= 1'b0;
                mem[aw_addr_q[9:2]] = w_data_q;
                {aw_got, w_got} = 2'b00;
            end
            pace(arvalid && !arready, ar_arm, ar_cnt, fire);
            if (fire) arready <= 1'b1;
            pace(r_pend && !rvalid, r_arm, r_cnt, fire);
            if (fire) begin
                rvalid <= 1'b1;
                rdata  <= mem[r_addr[9:2]];
            end
            pace(awvalid && !awready, aw_arm, aw_cnt, fire);
            if (fire) awready <= 1'b1;
            pace(wvalid && !wready, w_arm, w_cnt, fire);
            if (fire) wready <= 1'b1;
            pace(aw_got && w_got && !bvalid, b_arm, b_cnt, fire);
            if (fire) bvalid <= 1'b1;
        end
    end

    // Compares each write, in order, with the reference trace.
    always @(posedge CLK) begin
        int t;
        if (rst_n && awvalid && awready) begin
            if (aw_seen < exp_addr.size()) begin
                t = exp_test[aw_seen];
                check_word("awaddr", awaddr, exp_addr[aw_seen], t);
                store_seen[t]++;
            end else begin
                $display("%0t store to %h is not part of the expected trace", $time, awaddr);
                err_cnt++;
            end
            aw_seen++;
        end
        if (rst_n && wvalid && wready) begin
            if (w_seen < exp_data.size()) begin
                check_word("wdata", wdata, exp_data[w_seen], exp_test[w_seen]);
                check_word("wstrb", word_t'(wstrb), 32'h0000_000F, exp_test[w_seen]);
            end
            w_seen++;
        end
    end

    initial begin
        longint limit;
        wait (ref_ready);
        limit = 20 * longint'(ref_count) * WORST_LAT;
        #(limit * CLK_PERIOD);
        $display("timeout: halt never came within %0d cycles", limit);
        $display("Something failed");
        $finish;
    end

    initial begin
        int exp_n [4];
        int idle;
        bit stayed;
        bit silent;
        load_program();
        mem = image;
        ref_count = run_reference();
        ref_ready = 1'b1;
        foreach (exp_n[i]) exp_n[i] = 0;
        foreach (exp_test[i]) exp_n[exp_test[i]]++;
        repeat (3) @(posedge CLK);
        rst_n <= 1'b1;
        while (!halt) @(posedge CLK);
        idle = 0;
        while (idle < 20 && (arvalid || rready || awvalid || wvalid || bready)) begin
            @(posedge CLK);
            idle++;
        end
        report_test(1, "ALU chain through forwarding", test_err[0] == 0 && store_seen[0] == exp_n[0]);
        report_test(2, "load followed by dependent use", test_err[1] == 0 && store_seen[1] == exp_n[1]);
        report_test(3, "counted loop with BNE and BEQ", test_err[2] == 0 && store_seen[2] == exp_n[2]);
        report_test(4, "JAL and JR round trip", test_err[3] == 0 && store_seen[3] == exp_n[3]);
        report_test(5, "store trace under random latency",
                    err_cnt == 0 && aw_seen == exp_addr.size() && w_seen == exp_data.size()
                    && waited > 0);
        stayed = 1'b1;
        silent = (idle < 20);
        if (!silent) $display("bus still busy 20 cycles after halt rose");
        repeat (50) begin
            @(posedge CLK);
            if (!halt) stayed = 1'b0;
            if (arvalid || awvalid || wvalid) silent = 1'b0;
        end
        if (!stayed) $display("halt dropped after it rose");
        report_test(6, "halt holds and bus stays quiet", stayed && silent);
        $display("%0d tests: %0d passed, %0d failed, %0d value mismatches",
                 n_pass + n_fail, n_pass, n_fail, err_cnt);
        if (n_fail == 0 && err_cnt == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule

/* vlog.f */
+incdir+rtl
rtl/cpu_types_pkg.sv
rtl/branch_predictor.sv
rtl/hazard_unit.sv
rtl/mem_arbiter.sv
rtl/pipeline_datapath.sv
rtl/cpu_top.sv
bench/cpu_props.sv
bench/cpu_tb.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= cpu_tb
FILELIST  ?= vlog.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0
PASS_MSG  ?= Everything OK

SRCS := $(shell grep -v '^+' $(FILELIST)) $(wildcard rtl/*.svh)
BIN  := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: $(BIN)

$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR) -o V$(TOP)

run: $(BIN)
	@out="$$($(BIN))"; echo "$$out"; echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
